// ==== Bender.yml ====
package:
  name: fpnc

sources:
  - design/fpnc_pkg.sv
  - design/fpnc_req_if.sv
  - design/fpnc_decoder.sv
  - design/fpnc_hold_buffer.sv
  - design/fpnc_noncomp_unit.sv
  - design/fpnc_top.sv
  - target: test
    files:
      - bench/tb_clk_gen.sv
      - bench/tb_fpnc_top.sv

// ==== bench/tb_clk_gen.sv ====
// Testbench clock source
// Free-running clock with a 4 ns period
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int HalfPeriod = 2  // ns
) (
    output logic clk_o
);

    initial begin
        clk_o = 1'b0;
    end

    always #(HalfPeriod) clk_o = ~clk_o;

endmodule

`default_nettype wire

// ==== bench/tb_fpnc_top.sv ====
// Testbench for the FP32 non-computational unit
// Table-driven stimulus with random back-pressure, in-order checks and a flush test
`timescale 1ns/1ps
`default_nettype none

module tb_fpnc_top import fpnc_pkg::*; ();

    localparam int Timeout = 200;  // Cycles per wait
    localparam int MaxRows = 64;

    logic        clk_i;
    logic        rst_ni;
    logic        flush_i;
    logic        valid_i;
    logic        ready_o;
    fu_op_e      operation_i;
    logic [2:0]  rm_i;
    logic [31:0] operand_a_i;
    logic [31:0] operand_b_i;
    logic [2:0]  trans_id_i;
    logic        out_ready_i;
    logic        valid_o;
    logic [31:0] result_o;
    logic [4:0]  status_o;
    logic [2:0]  trans_id_o;

    // Stimulus and expected values, one row per request
    fu_op_e      tab_op  [MaxRows];
    logic [2:0]  tab_rm  [MaxRows];
    logic [31:0] tab_a   [MaxRows];
    logic [31:0] tab_b   [MaxRows];
    logic [31:0] tab_res [MaxRows];
    logic        tab_nv  [MaxRows];
    int          n_rows = 0;

    int          exp_q[$];      // Row indices in flight, issue order
    int          done_count = 0;
    int          val_errs   = 0;
    int          prot_errs  = 0;
    logic        timed_out  = 1'b0;
    logic        hold_low;      // Forces out_ready_i low
    logic [31:0] lfsr = 32'h94d0;
    logic        was_stalled = 1'b0;
    logic [31:0] held_result;

    tb_clk_gen u_clk_gen (.clk_o(clk_i));

    fpnc_top u_dut (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .flush_i     (flush_i),
        .valid_i     (valid_i),
        .ready_o     (ready_o),
        .operation_i (operation_i),
        .rm_i        (rm_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .trans_id_i  (trans_id_i),
        .out_ready_i (out_ready_i),
        .valid_o     (valid_o),
        .result_o    (result_o),
        .status_o    (status_o),
        .trans_id_o  (trans_id_o)
    );

    // Galois LFSR, one step per bit
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
    endfunction

    task automatic add_row(input fu_op_e op, input logic [2:0] rm, input logic [31:0] a,
                           input logic [31:0] b, input logic [31:0] res, input logic nv);
        tab_op[n_rows]  = op;
        tab_rm[n_rows]  = rm;
        tab_a[n_rows]   = a;
        tab_b[n_rows]   = b;
        tab_res[n_rows] = res;
        tab_nv[n_rows]  = nv;
        n_rows++;
    endtask

    task automatic load_table();
        // Sign injection, result is a with a new sign
        add_row(FSGNJ, 3'd0, 32'h3f800000, 32'hc0000000, 32'hbf800000, 1'b0);
        add_row(FSGNJ, 3'd1, 32'h3f800000, 32'hc0000000, 32'h3f800000, 1'b0);
        add_row(FSGNJ, 3'd2, 32'hbf800000, 32'hc0000000, 32'h3f800000, 1'b0);
        add_row(FSGNJ, 3'd2, 32'h3f800000, 32'hc0000000, 32'hbf800000, 1'b0);
        add_row(FSGNJ, 3'd3, 32'hbf800000, 32'h40000000, 32'hbf800000, 1'b0);
        add_row(FMV,   3'd0, 32'h7f800001, 32'h00000000, 32'h7f800001, 1'b0);  // No quieting
        add_row(FNOP,  3'd0, 32'h12345678, 32'h00000000, 32'h12345678, 1'b0);
        // Min/max
        add_row(FMIN_MAX, 3'd0, 32'h3f800000, 32'h40000000, 32'h3f800000, 1'b0);
        add_row(FMIN_MAX, 3'd1, 32'h3f800000, 32'h40000000, 32'h40000000, 1'b0);
        add_row(FMIN_MAX, 3'd2, 32'h3f800000, 32'h40000000, 32'h3f800000, 1'b0);  // rm[0] only
        add_row(FMIN_MAX, 3'd0, 32'hbf800000, 32'hc0000000, 32'hc0000000, 1'b0);
        add_row(FMIN_MAX, 3'd1, 32'hbf800000, 32'hc0000000, 32'hbf800000, 1'b0);
        add_row(FMIN_MAX, 3'd0, 32'h00000000, 32'h80000000, 32'h80000000, 1'b0);  // -0 < +0
        add_row(FMIN_MAX, 3'd1, 32'h80000000, 32'h00000000, 32'h00000000, 1'b0);
        add_row(FMIN_MAX, 3'd0, 32'h7fc00000, 32'h40000000, 32'h40000000, 1'b0);
        add_row(FMIN_MAX, 3'd1, 32'h3f800000, 32'h7f800001, 32'h3f800000, 1'b1);
        add_row(FMIN_MAX, 3'd0, 32'h7f800001, 32'hffc00000, CANON_NAN,    1'b1);
        add_row(FMIN_MAX, 3'd1, 32'hffc00000, 32'h7fc00000, CANON_NAN,    1'b0);
        // Comparisons, answer in bit 0
        add_row(FCMP, 3'd0, 32'h3f800000, 32'h40000000, 32'h00000001, 1'b0);
        add_row(FCMP, 3'd0, 32'h40000000, 32'h3f800000, 32'h00000000, 1'b0);
        add_row(FCMP, 3'd0, 32'h3f800000, 32'h3f800000, 32'h00000001, 1'b0);
        add_row(FCMP, 3'd1, 32'h3f800000, 32'h3f800000, 32'h00000000, 1'b0);
        add_row(FCMP, 3'd1, 32'hc0000000, 32'hbf800000, 32'h00000001, 1'b0);
        add_row(FCMP, 3'd1, 32'h80000000, 32'h00000000, 32'h00000000, 1'b0);
        add_row(FCMP, 3'd2, 32'h00000000, 32'h80000000, 32'h00000001, 1'b0);  // +0 == -0
        add_row(FCMP, 3'd2, 32'h3f800000, 32'h40000000, 32'h00000000, 1'b0);
        add_row(FCMP, 3'd2, 32'h7fc00000, 32'h7fc00000, 32'h00000000, 1'b0);  // Quiet EQ
        add_row(FCMP, 3'd2, 32'h7f800001, 32'h3f800000, 32'h00000000, 1'b1);
        add_row(FCMP, 3'd0, 32'h7fc00000, 32'h3f800000, 32'h00000000, 1'b1);
        add_row(FCMP, 3'd1, 32'h3f800000, 32'h7fc00000, 32'h00000000, 1'b1);
        add_row(FCMP, 3'd3, 32'h3f800000, 32'h40000000, 32'h00000000, 1'b0);
        // Classification, one row per class
        add_row(FCLASS, 3'd0, 32'hff800000, 32'h0, 32'h00000001, 1'b0);  // -inf
        add_row(FCLASS, 3'd0, 32'hbf800000, 32'h0, 32'h00000002, 1'b0);
        add_row(FCLASS, 3'd0, 32'h80000001, 32'h0, 32'h00000004, 1'b0);
        add_row(FCLASS, 3'd0, 32'h80000000, 32'h0, 32'h00000008, 1'b0);
        add_row(FCLASS, 3'd0, 32'h00000000, 32'h0, 32'h00000010, 1'b0);
        add_row(FCLASS, 3'd0, 32'h00400000, 32'h0, 32'h00000020, 1'b0);  // +subnormal
        add_row(FCLASS, 3'd0, 32'h3f800000, 32'h0, 32'h00000040, 1'b0);
        add_row(FCLASS, 3'd0, 32'h7f800000, 32'h0, 32'h00000080, 1'b0);
        add_row(FCLASS, 3'd0, 32'h7fa00000, 32'h0, 32'h00000100, 1'b0);  // sNaN
        add_row(FCLASS, 3'd0, 32'hffc00000, 32'h0, 32'h00000200, 1'b0);  // qNaN, sign ignored
    endtask

    // ----------------------------------------
    // Issue side
    // ----------------------------------------
    task automatic drive_row(input int row);
        valid_i     <= 1'b1;
        operation_i <= tab_op[row];
        rm_i        <= tab_rm[row];
        operand_a_i <= tab_a[row];
        operand_b_i <= tab_b[row];
        trans_id_i  <= 3'(row % 8);
    endtask

    // Ends on the edge that takes the request
    task automatic wait_accept();
        int cycles;
        cycles = 0;
        if (!timed_out) begin
            @(negedge clk_i);
            while (!ready_o && cycles < Timeout) begin
                @(negedge clk_i);
                cycles++;
            end
            if (!ready_o) begin
                timed_out = 1'b1;
                prot_errs++;
                $display("Timeout at %0t: request was never accepted", $time);
            end else begin
                @(posedge clk_i);
            end
        end
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (!timed_out && exp_q.size() > 0 && cycles < Timeout) begin
            @(posedge clk_i);
            cycles++;
        end
        if (!timed_out && exp_q.size() > 0) begin
            timed_out = 1'b1;
            prot_errs++;
            $display("Timeout at %0t: %0d results never came back", $time, exp_q.size());
        end
    endtask

    task automatic run_table();
        int i;
        for (i = 0; i < n_rows; i++) begin
            drive_row(i);
            wait_accept();
            exp_q.push_back(i);
        end
        valid_i <= 1'b0;
    endtask

    // One result parked at the output, one request parked in the buffer, then flush
    task automatic flush_test();
        int k;
        hold_low <= 1'b1;
        @(posedge clk_i);       // out_ready_i low from here
        drive_row(0);
        wait_accept();
        exp_q.push_back(0);
        drive_row(1);
        @(posedge clk_i);       // Buffer captures row 1
        @(negedge clk_i);
        if (!valid_o) begin     // Row 0 must sit in the output register
            prot_errs++;
            $display("ERROR %0t valid_o: got %b expected %b", $time, valid_o, 1'b1);
        end
        if (ready_o) begin      // Row 1 must sit in the buffer
            prot_errs++;
            $display("ERROR %0t ready_o: got %b expected %b", $time, ready_o, 1'b0);
        end
        @(posedge clk_i);
        flush_i <= 1'b1;
        valid_i <= 1'b0;        // Issue drops the stalled request
        @(posedge clk_i);
        flush_i <= 1'b0;
        exp_q.delete();         // Both requests are gone
        for (k = 0; k < 8; k++) begin
            @(negedge clk_i);
            if (valid_o) begin
                prot_errs++;
                $display("ERROR %0t valid_o: got %b expected %b", $time, valid_o, 1'b0);
            end
        end
        @(posedge clk_i);
        hold_low <= 1'b0;
    endtask

    // ----------------------------------------
    // Writeback back-pressure
    // ----------------------------------------
    always @(posedge clk_i) begin : p_out_ready
        if (hold_low) begin
            out_ready_i <= 1'b0;
        end else begin
            lfsr = lfsr_next(lfsr);
            out_ready_i <= lfsr[0];  // Roughly half the cycles
        end
    end

    // ----------------------------------------
    // Checker, sampled mid-cycle
    // ----------------------------------------
    always @(negedge clk_i) begin : p_check
        int idx;
        if (rst_ni) begin
            // Stalled output must not move
            if (was_stalled && !valid_o) begin
                prot_errs++;
                $display("ERROR %0t valid_o: got %b expected %b", $time, valid_o, 1'b1);
            end else if (was_stalled && result_o !== held_result) begin
                val_errs++;
                $display("ERROR %0t result_o: got %h expected %h", $time, result_o, held_result);
            end
            if (valid_o && out_ready_i) begin
                if (exp_q.size() == 0) begin
                    prot_errs++;
                    $display("Unexpected result at %0t with nothing in flight", $time);
                end else begin
                    idx = exp_q.pop_front();
                    done_count++;
                    if (result_o !== tab_res[idx]) begin
                        val_errs++;
                        $display("ERROR %0t result_o: got %h expected %h", $time, result_o,
                                 tab_res[idx]);
                    end
                    if (status_o !== {tab_nv[idx], 4'b0000}) begin
                        val_errs++;
                        $display("ERROR %0t status_o: got %b expected %b", $time, status_o,
                                 {tab_nv[idx], 4'b0000});
                    end
                    if (trans_id_o !== 3'(idx % 8)) begin
                        val_errs++;
                        $display("ERROR %0t trans_id_o: got %0d expected %0d", $time, trans_id_o,
                                 idx % 8);
                    end
                end
            end
            was_stalled = valid_o && !out_ready_i && !flush_i;
            held_result = result_o;
        end
    end

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------
    initial begin : p_main
        rst_ni      = 1'b0;
        flush_i     = 1'b0;
        valid_i     = 1'b0;
        operation_i = FNOP;
        rm_i        = 3'd0;
        operand_a_i = '0;
        operand_b_i = '0;
        trans_id_i  = '0;
        out_ready_i = 1'b0;
        hold_low    = 1'b0;
        load_table();
        repeat (4) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(posedge clk_i);

        run_table();
        wait_drain();
        flush_test();
        run_table();            // Unit still correct after flush
        wait_drain();

        if (!timed_out && done_count != 2 * n_rows) begin
            prot_errs++;
            $display("Got %0d results instead of %0d", done_count, 2 * n_rows);
        end
        $display("Results: %0d, value errors: %0d, protocol errors: %0d",
                 done_count, val_errs, prot_errs);
        if (val_errs == 0 && prot_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== design/fpnc_decoder.sv ====
// Issue-side decoder for the non-computational unit
// Maps issue operation and rm onto unit operation fields, no latency
`timescale 1ns/1ps
`default_nettype none

module fpnc_decoder import fpnc_pkg::*; #(
    parameter int unsigned TransIdBits = TRANS_ID_BITS
) (
    input  logic                   valid_i,
    output logic                   ready_o,
    input  fu_op_e                 operation_i,
    input  logic [2:0]             rm_i,
    input  logic [FLEN-1:0]        operand_a_i,
    input  logic [FLEN-1:0]        operand_b_i,
    input  logic [TransIdBits-1:0] trans_id_i,
    fpnc_req_if.source             req
);

    // ----------------------------------------
    // Handshake and payload passthrough
    // ----------------------------------------
    assign req.valid = valid_i;
    assign ready_o   = req.ready;  // Token comes straight from the buffer

    assign req.operand_a = operand_a_i;
    assign req.operand_b = operand_b_i;
    assign req.tag       = trans_id_i;

    // ----------------------------------------
    // Operation translation
    // ----------------------------------------
    // Only rm[1:0] selects a variant, bit 2 has no meaning for FP32 ops
    always_comb begin : p_translate
        req.op     = PASS;  // Safe default
        req.sub_op = rm_i[1:0];

        case (operation_i)
            // SGNJ, SGNJN, SGNJX, rm 3 passes a through
            FSGNJ: begin
                req.op = SGNJ;
            end
            // Min or max from rm bit 0 alone
            FMIN_MAX: begin
                req.op     = MINMAX;
                req.sub_op = {1'b0, rm_i[0]};
            end
            FCMP: begin
                req.op = CMP;  // LE, LT, EQ
            end
            FCLASS: begin
                req.op     = CLASSIFY;
                req.sub_op = 2'b00;  // Variant unused
            end
            // Moves carry the bits unchanged
            FMV: begin
                req.op     = PASS;
                req.sub_op = 2'b00;
            end
            FNOP: begin
                req.op     = PASS;
                req.sub_op = 2'b00;
            end
            default: begin
                req.op     = PASS;  // Unknown codes behave like a NOP
                req.sub_op = 2'b00;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== design/fpnc_hold_buffer.sv ====
// Protocol inversion buffer between decoder and execution unit
// Catches a request the unit refuses and replays it, READY/STALL FSM
`timescale 1ns/1ps
`default_nettype none

module fpnc_hold_buffer import fpnc_pkg::*; #(
    parameter int unsigned TransIdBits = TRANS_ID_BITS
) (
    input  logic     clk_i,
    input  logic     rst_ni,
    input  logic     flush_i,
    fpnc_req_if.sink up,
    fpnc_req_if.source down
);

    localparam logic READY = 1'b0;  // Live request goes through
    localparam logic STALL = 1'b1;  // Held copy waits for the unit

    logic state_q, state_d;
    logic hold_inputs;  // Capture the live request this edge
    logic use_hold;     // Present the held copy downstream

    // Hold register
    unit_op_e               op_q;
    logic [1:0]             sub_op_q;
    fp32_u                  operand_a_q;
    fp32_u                  operand_b_q;
    logic [TransIdBits-1:0] tag_q;

    // ----------------------------------------
    // READY/STALL control
    // ----------------------------------------
    always_comb begin : p_inversion_fsm
        up.ready    = 1'b0;
        down.valid  = 1'b0;
        hold_inputs = 1'b0;
        use_hold    = 1'b0;
        state_d     = state_q;

        case (state_q)
            READY: begin
                up.ready   = down.ready;  // Issue sees the unit directly
                down.valid = up.valid;
                // Unit busy, keep a copy and block issue
                if (up.valid && !down.ready) begin
                    hold_inputs = 1'b1;
                    state_d     = STALL;
                end
            end
            STALL: begin
                down.valid = 1'b1;
                use_hold   = 1'b1;
                // Unit takes the copy, completes the issue handshake too
                if (down.ready) begin
                    up.ready = 1'b1;
                    state_d  = READY;
                end
            end
            default: state_d = READY;
        endcase

        if (flush_i) state_d = READY;  // Held request is dropped
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_state
        if (!rst_ni) begin
            state_q <= READY;
        end else begin
            state_q <= state_d;
        end
    end

    // Payload only, written on a stall
    always_ff @(posedge clk_i) begin : p_hold_reg
        if (hold_inputs) begin
            op_q        <= up.op;
            sub_op_q    <= up.sub_op;
            operand_a_q <= up.operand_a;
            operand_b_q <= up.operand_b;
            tag_q       <= up.tag;
        end
    end

    // Held or live request towards the unit
    assign down.op        = use_hold ? op_q        : up.op;
    assign down.sub_op    = use_hold ? sub_op_q    : up.sub_op;
    assign down.operand_a = use_hold ? operand_a_q : up.operand_a;
    assign down.operand_b = use_hold ? operand_b_q : up.operand_b;
    assign down.tag       = use_hold ? tag_q       : up.tag;

endmodule

`default_nettype wire

// ==== design/fpnc_noncomp_unit.sv ====
// FP32 non-computational execution unit
// Sign injection, min/max, compare, classify and move, one output stage
`timescale 1ns/1ps
`default_nettype none

module fpnc_noncomp_unit import fpnc_pkg::*; #(
    parameter int unsigned TransIdBits = TRANS_ID_BITS
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   flush_i,
    fpnc_req_if.sink               req,
    input  logic                   out_ready_i,
    output logic                   valid_o,
    output logic [FLEN-1:0]        result_o,
    output logic [4:0]             status_o,
    output logic [TransIdBits-1:0] trans_id_o
);

    // One-hot FCLASS vector of an operand
    function automatic logic [9:0] fp_class(input fp32_u x);
        logic       exp_max;
        logic       exp_zero;
        logic       man_zero;
        logic [9:0] cls;
        exp_max  = &x.f.exponent;
        exp_zero = ~|x.f.exponent;
        man_zero = ~|x.f.mantissa;
        cls      = '0;
        if (exp_max && !man_zero) begin
            cls[x.f.mantissa[22] ? CLASS_QNAN : CLASS_SNAN] = 1'b1;  // Sign ignored
        end else if (exp_max) begin
            cls[x.f.sign ? CLASS_NEG_INF : CLASS_POS_INF] = 1'b1;
        end else if (exp_zero && man_zero) begin
            cls[x.f.sign ? CLASS_NEG_ZERO : CLASS_POS_ZERO] = 1'b1;
        end else if (exp_zero) begin
            cls[x.f.sign ? CLASS_NEG_SUB : CLASS_POS_SUB] = 1'b1;
        end else begin
            cls[x.f.sign ? CLASS_NEG_NORM : CLASS_POS_NORM] = 1'b1;
        end
        return cls;
    endfunction

    fp32_u      a, b;
    logic [9:0] cls_a, cls_b;
    logic       a_nan, b_nan, a_snan, b_snan, any_nan, both_zero;
    logic       a_lt_raw;   // Total order, -0 below +0
    logic       cmp_lt, cmp_eq;
    logic [FLEN-1:0] result_d;
    logic            nv_d;
    logic [4:0]      status_d;

    logic                   valid_q;
    logic [FLEN-1:0]        result_q;
    logic [4:0]             status_q;
    logic [TransIdBits-1:0] tag_q;

    // ----------------------------------------
    // Operand analysis
    // ----------------------------------------
    assign a     = req.operand_a;
    assign b     = req.operand_b;
    assign cls_a = fp_class(a);
    assign cls_b = fp_class(b);

    assign a_snan    = cls_a[CLASS_SNAN];
    assign b_snan    = cls_b[CLASS_SNAN];
    assign a_nan     = cls_a[CLASS_SNAN] | cls_a[CLASS_QNAN];
    assign b_nan     = cls_b[CLASS_SNAN] | cls_b[CLASS_QNAN];
    assign any_nan   = a_nan | b_nan;
    assign both_zero = (cls_a[CLASS_NEG_ZERO] | cls_a[CLASS_POS_ZERO]) &
                       (cls_b[CLASS_NEG_ZERO] | cls_b[CLASS_POS_ZERO]);

    // Sign-magnitude ordering, larger magnitude is smaller when negative
    always_comb begin : p_order
        if (a.f.sign != b.f.sign) begin
            a_lt_raw = a.f.sign;
        end else if (a.f.sign) begin
            a_lt_raw = a.bits[FLEN-2:0] > b.bits[FLEN-2:0];
        end else begin
            a_lt_raw = a.bits[FLEN-2:0] < b.bits[FLEN-2:0];
        end
    end

    assign cmp_lt = a_lt_raw & ~both_zero;              // +0 and -0 compare equal
    assign cmp_eq = (a.bits == b.bits) | both_zero;

    // ----------------------------------------
    // Result select
    // ----------------------------------------
    always_comb begin : p_result
        result_d = a.bits;
        nv_d     = 1'b0;
        case (req.op)
            SGNJ: begin
                case (req.sub_op)
                    2'd0:    result_d = {b.f.sign, a.bits[FLEN-2:0]};
                    2'd1:    result_d = {~b.f.sign, a.bits[FLEN-2:0]};
                    2'd2:    result_d = {a.f.sign ^ b.f.sign, a.bits[FLEN-2:0]};
                    default: result_d = a.bits;
                endcase
            end
            MINMAX: begin
                nv_d = a_snan | b_snan;  // Quiet NaNs are silent
                if (a_nan && b_nan)  result_d = CANON_NAN;
                else if (a_nan)      result_d = b.bits;
                else if (b_nan)      result_d = a.bits;
                else if (req.sub_op[0]) result_d = a_lt_raw ? b.bits : a.bits;  // Max
                else                 result_d = a_lt_raw ? a.bits : b.bits;     // Min
            end
            CMP: begin
                result_d = '0;
                case (req.sub_op)
                    2'd0: begin  // LE, signaling on any NaN
                        result_d[0] = ~any_nan & (cmp_lt | cmp_eq);
                        nv_d        = any_nan;
                    end
                    2'd1: begin  // LT
                        result_d[0] = ~any_nan & cmp_lt;
                        nv_d        = any_nan;
                    end
                    2'd2: begin  // EQ, quiet compare
                        result_d[0] = ~any_nan & cmp_eq;
                        nv_d        = a_snan | b_snan;
                    end
                    default: result_d = '0;
                endcase
            end
            CLASSIFY: result_d = {{(FLEN-10){1'b0}}, cls_a};
            default:  result_d = a.bits;  // PASS
        endcase
    end

    always_comb begin : p_status
        status_d            = '0;
        status_d[STATUS_NV] = nv_d;
    end

    // ----------------------------------------
    // Output stage
    // ----------------------------------------
    assign req.ready = ~valid_q | out_ready_i;  // Empty or draining

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_valid
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;  // Drops held and just accepted results
        end else if (req.ready) begin
            valid_q <= req.valid;
        end
    end

    always_ff @(posedge clk_i) begin : p_payload
        if (req.valid && req.ready) begin
            result_q <= result_d;
            status_q <= status_d;
            tag_q    <= req.tag;
        end
    end

    assign valid_o    = valid_q;
    assign result_o   = result_q;
    assign status_o   = status_q;
    assign trans_id_o = tag_q;

endmodule

`default_nettype wire

// ==== design/fpnc_pkg.sv ====
// FP32 non-computational unit shared definitions
// Operand layout, operation codes, status and class bit positions
`default_nettype none

package fpnc_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int unsigned FLEN          = 32;  // Scalar FP32 only
    localparam int unsigned TRANS_ID_BITS = 3;   // Default tag width

    // Operation codes as the issue stage sends them
    typedef enum logic [2:0] {
        FSGNJ    = 3'd0,  // Sign injection, variant in rm
        FMIN_MAX = 3'd1,  // Min or max, rm bit 0
        FCMP     = 3'd2,  // LE, LT, EQ in rm
        FCLASS   = 3'd3,
        FMV      = 3'd4,  // Bit move, no recoding
        FNOP     = 3'd5
    } fu_op_e;

    // Operations the unit itself knows about
    typedef enum logic [2:0] {
        SGNJ     = 3'd0,
        MINMAX   = 3'd1,
        CMP      = 3'd2,
        CLASSIFY = 3'd3,
        PASS     = 3'd4   // Operand a straight through
    } unit_op_e;

    // ----------------------------------------
    // Operand word
    // ----------------------------------------
    // Same 32 bits, read raw or as IEEE 754 fields
    typedef union packed {
        logic [FLEN-1:0] bits;
        struct packed {
            logic        sign;
            logic [7:0]  exponent;
            logic [22:0] mantissa;  // Bit 22 is the quiet bit for NaNs
        } f;
    } fp32_u;

    localparam logic [FLEN-1:0] CANON_NAN = 32'h7fc00000;  // Positive quiet NaN

    // Status is {NV, DZ, OF, UF, NX}, only NV can fire here
    localparam int unsigned STATUS_NV = 4;

    // FCLASS result bits in RISC-V order
    localparam int unsigned CLASS_NEG_INF  = 0;
    localparam int unsigned CLASS_NEG_NORM = 1;
    localparam int unsigned CLASS_NEG_SUB  = 2;
    localparam int unsigned CLASS_NEG_ZERO = 3;
    localparam int unsigned CLASS_POS_ZERO = 4;
    localparam int unsigned CLASS_POS_SUB  = 5;
    localparam int unsigned CLASS_POS_NORM = 6;
    localparam int unsigned CLASS_POS_INF  = 7;
    localparam int unsigned CLASS_SNAN     = 8;
    localparam int unsigned CLASS_QNAN     = 9;

endpackage

`default_nettype wire

// ==== design/fpnc_req_if.sv ====
// Decoded request channel with valid/ready handshake
// Used between decoder, hold buffer and execution unit
`timescale 1ns/1ps
`default_nettype none

interface fpnc_req_if import fpnc_pkg::*; #(
    parameter int unsigned TransIdBits = TRANS_ID_BITS
) ();

    logic                   valid;      // Request present
    logic                   ready;      // Sink takes it this edge
    unit_op_e               op;
    logic [1:0]             sub_op;     // Variant within op
    fp32_u                  operand_a;
    fp32_u                  operand_b;
    logic [TransIdBits-1:0] tag;        // Transaction ID, returned with result

    // Producer side
    modport source (
        output valid, op, sub_op, operand_a, operand_b, tag,
        input  ready
    );

    // Consumer side
    modport sink (
        input  valid, op, sub_op, operand_a, operand_b, tag,
        output ready
    );

endinterface

`default_nettype wire

// ==== design/fpnc_top.sv ====
// Top level of the FP32 non-computational unit
// Decoder, protocol inversion buffer and execution unit in a chain
`timescale 1ns/1ps
`default_nettype none

module fpnc_top import fpnc_pkg::*; #(
    parameter int unsigned TransIdBits = TRANS_ID_BITS
) (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   flush_i,
    // Issue side
    input  logic                   valid_i,
    output logic                   ready_o,
    input  fu_op_e                 operation_i,
    input  logic [2:0]             rm_i,
    input  logic [FLEN-1:0]        operand_a_i,
    input  logic [FLEN-1:0]        operand_b_i,
    input  logic [TransIdBits-1:0] trans_id_i,
    // Writeback side
    input  logic                   out_ready_i,
    output logic                   valid_o,
    output logic [FLEN-1:0]        result_o,
    output logic [4:0]             status_o,
    output logic [TransIdBits-1:0] trans_id_o
);

    fpnc_req_if #(.TransIdBits(TransIdBits)) dec_if ();  // Decoder to buffer
    fpnc_req_if #(.TransIdBits(TransIdBits)) exe_if ();  // Buffer to unit

    fpnc_decoder #(.TransIdBits(TransIdBits)) u_decoder (
        .valid_i     (valid_i),
        .ready_o     (ready_o),
        .operation_i (operation_i),
        .rm_i        (rm_i),
        .operand_a_i (operand_a_i),
        .operand_b_i (operand_b_i),
        .trans_id_i  (trans_id_i),
        .req         (dec_if.source)
    );

    fpnc_hold_buffer #(.TransIdBits(TransIdBits)) u_hold_buffer (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .flush_i (flush_i),
        .up      (dec_if.sink),
        .down    (exe_if.source)
    );

    fpnc_noncomp_unit #(.TransIdBits(TransIdBits)) u_noncomp_unit (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .flush_i     (flush_i),
        .req         (exe_if.sink),
        .out_ready_i (out_ready_i),
        .valid_o     (valid_o),
        .result_o    (result_o),
        .status_o    (status_o),
        .trans_id_o  (trans_id_o)
    );

endmodule

`default_nettype wire

// ==== src.f ====
design/fpnc_pkg.sv
design/fpnc_req_if.sv
design/fpnc_decoder.sv
design/fpnc_hold_buffer.sv
design/fpnc_noncomp_unit.sv
design/fpnc_top.sv
bench/tb_clk_gen.sv
bench/tb_fpnc_top.sv
